// ==== include/ctrl_macros.svh ====
// Controller macros, widths and counts shared by the pipeline control unit
`ifndef CTRL_MACROS_SVH
`define CTRL_MACROS_SVH

`define INSN_W      32
`define REG_ADDR_W  5

// Pipeline registers, bit 0 IF/ID up to bit 3 MEM/WB
`define PIPEREG_N   4

`define BYPASS_W    3

// Link register for jal
`define LINK_REG    5'd31

`endif

// ==== source/isa_pkg.sv ====
// ISA package, opcode, function and ALU operation encodings with the instruction layout
`default_nettype none
`include "ctrl_macros.svh"

package isa_pkg;

    localparam int OPCODE_W = 6;
    // What remains after opcode, rs, rt, rd and shamt
    localparam int FUNCT_W  = `INSN_W - OPCODE_W - 4 * `REG_ADDR_W;

    typedef enum logic [OPCODE_W-1:0] {
        OP_R_TYPE = 6'h00, OP_J     = 6'h02, OP_JAL   = 6'h03,
        OP_BEQ    = 6'h04, OP_BNE   = 6'h05, OP_ADDI  = 6'h08,
        OP_ADDIU  = 6'h09, OP_SLTI  = 6'h0a, OP_SLTIU = 6'h0b,
        OP_ANDI   = 6'h0c, OP_ORI   = 6'h0d, OP_XORI  = 6'h0e,
        OP_LUI    = 6'h0f, OP_LW    = 6'h23, OP_SW    = 6'h2b
    } opcode_t;

    typedef enum logic [FUNCT_W-1:0] {
        FN_SLL  = 6'h00, FN_SRL  = 6'h02, FN_SRA = 6'h03, FN_SLLV = 6'h04,
        FN_SRLV = 6'h06, FN_SRAV = 6'h07, FN_ADD = 6'h20, FN_ADDU = 6'h21,
        FN_SUB  = 6'h22, FN_SUBU = 6'h23, FN_AND = 6'h24, FN_OR   = 6'h25,
        FN_XOR  = 6'h26, FN_NOR  = 6'h27, FN_SLT = 6'h2a, FN_SLTU = 6'h2b
    } funct_t;

    // Encoding order as seen by the ALU
    typedef enum logic [3:0] {
        ALU_AND,  ALU_OR,   ALU_ADD,  ALU_SRA,
        ALU_SLL,  ALU_SRL,  ALU_SUB,  ALU_SLT,
        ALU_ADDU, ALU_SUBU, ALU_SLTU, ALU_XOR,
        ALU_NOR,  ALU_SRAV, ALU_SLLV, ALU_SRLV
    } alu_op_t;

    // I-type immediates overlay rd, shamt and funct
    typedef struct packed {
        opcode_t                 opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] shamt;
        funct_t                  funct;
    } insn_t;

endpackage

`default_nettype wire

// ==== source/ctrl_pkg.sv ====
// Controller package, control word, destination tracking and bypass select types
`default_nettype none
`include "ctrl_macros.svh"

package ctrl_pkg;

    typedef enum logic [1:0] {
        PC_SEQ    = 2'd0,
        PC_BRANCH = 2'd1,
        PC_JUMP   = 2'd2
    } pc_src_t;

    // reg_dest: 00 rt, 01 rd, 10 link
    // data_to_reg: 00 ALU, 01 memory, 10 return address, 11 upper immediate
    typedef struct packed {
        isa_pkg::alu_op_t alu_op;
        logic             alu_a_shamt;
        logic             alu_b_imm;
        logic             ext_zero;
        logic             reg_write;
        logic [1:0]       reg_dest;
        logic [1:0]       data_to_reg;
        logic             mem_write;
        logic             mem_read;
    } ctrl_word_t;

    typedef enum logic [1:0] {RK_NONE, RK_ALU, RK_LUI, RK_LOAD} result_kind_t;

    // Register 0 or RK_NONE means no write
    typedef struct packed {
        logic [`REG_ADDR_W-1:0] addr;
        result_kind_t            kind;
    } dest_entry_t;

    localparam dest_entry_t DEST_NONE = '{addr: '0, kind: RK_NONE};

    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic                    uses_rs;
        logic                    uses_rt;
        logic                    is_branch;
    } src_use_t;

    typedef enum logic [`BYPASS_W-1:0] {
        BP_NONE     = 3'd0,
        BP_EX_ALU   = 3'd1,
        BP_EX_LUI   = 3'd3,
        BP_MEM_ALU  = 3'd4,
        BP_MEM_LUI  = 3'd6,
        BP_MEM_LOAD = 3'd7
    } bypass_sel_t;

endpackage

`default_nettype wire

// ==== source/hazard_if.sv ====
// Hazard interface, decode-stage sources and in-flight destinations for forwarding
`timescale 1ns/1ns
`default_nettype none

interface hazard_if;
    import ctrl_pkg::*;

    // Decode stage
    dest_entry_t id_dest;
    src_use_t    id_srcs;

    // Instructions in EX and MEM
    dest_entry_t ex_dest;
    dest_entry_t mem_dest;

    modport decoder (output id_dest, output id_srcs);
    modport tracker (input id_dest, output ex_dest, output mem_dest);
    modport bypass  (input id_dest, input id_srcs, input ex_dest, input mem_dest);

endinterface

`default_nettype wire

// ==== source/instr_decoder.sv ====
// Instruction decoder, ID-stage instruction to control word, next PC and register use
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
    input  wire isa_pkg::insn_t       id_insn,
    input  wire logic                 id_valid,
    input  wire logic                 branch_equal,
    output ctrl_pkg::ctrl_word_t      ctrl,
    output ctrl_pkg::pc_src_t         pc_src,
    hazard_if.decoder                 hz
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    logic    r_known;
    alu_op_t r_op;

    // I-type ALU group, result to rt
    function automatic ctrl_word_t imm_alu(alu_op_t op, logic zero_ext);
        ctrl_word_t c;
        c           = '0;
        c.alu_op    = op;
        c.alu_b_imm = 1'b1;
        c.ext_zero  = zero_ext;
        c.reg_write = 1'b1;
        return c;
    endfunction

    always_comb begin
        r_known = 1'b1;
        case (id_insn.funct)
            FN_AND:  r_op = ALU_AND;
            FN_OR:   r_op = ALU_OR;
            FN_ADD:  r_op = ALU_ADD;
            FN_SRA:  r_op = ALU_SRA;
            FN_SLL:  r_op = ALU_SLL;
            FN_SRL:  r_op = ALU_SRL;
            FN_SUB:  r_op = ALU_SUB;
            FN_SLT:  r_op = ALU_SLT;
            FN_ADDU: r_op = ALU_ADDU;
            FN_SUBU: r_op = ALU_SUBU;
            FN_SLTU: r_op = ALU_SLTU;
            FN_XOR:  r_op = ALU_XOR;
            FN_NOR:  r_op = ALU_NOR;
            FN_SRAV: r_op = ALU_SRAV;
            FN_SLLV: r_op = ALU_SLLV;
            FN_SRLV: r_op = ALU_SRLV;
            default: begin
                r_op    = ALU_AND;
                r_known = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////
    // Control word and next PC

    always_comb begin
        ctrl   = '0;
        pc_src = PC_SEQ;
        if (id_valid) begin
            case (id_insn.opcode)
                OP_R_TYPE: begin
                    if (r_known) begin
                        ctrl.alu_op      = r_op;
                        ctrl.alu_a_shamt = id_insn.funct inside {FN_SLL, FN_SRL, FN_SRA};
                        ctrl.reg_write   = 1'b1;
                        ctrl.reg_dest    = 2'b01;
                    end
                end
                OP_ADDI:  ctrl = imm_alu(ALU_ADD, 1'b0);
                OP_ANDI:  ctrl = imm_alu(ALU_AND, 1'b1);
                OP_ORI:   ctrl = imm_alu(ALU_OR, 1'b1);
                OP_XORI:  ctrl = imm_alu(ALU_XOR, 1'b1);
                OP_SLTI:  ctrl = imm_alu(ALU_SLT, 1'b0);
                OP_ADDIU: ctrl = imm_alu(ALU_ADDU, 1'b1);
                OP_SLTIU: ctrl = imm_alu(ALU_SLTU, 1'b1);
                OP_LW: begin
                    ctrl             = imm_alu(ALU_ADD, 1'b0);
                    ctrl.data_to_reg = 2'b01;
                    ctrl.mem_read    = 1'b1;
                end
                OP_SW: begin
                    ctrl           = imm_alu(ALU_ADD, 1'b0);
                    ctrl.reg_write = 1'b0;
                    ctrl.mem_write = 1'b1;
                end
                OP_BEQ: begin
                    ctrl.alu_op = ALU_SUB;
                    pc_src      = branch_equal ? PC_BRANCH : PC_SEQ;
                end
                OP_BNE: begin
                    ctrl.alu_op = ALU_SUB;
                    pc_src      = branch_equal ? PC_SEQ : PC_BRANCH;
                end
                OP_LUI: begin
                    ctrl.reg_write   = 1'b1;
                    ctrl.data_to_reg = 2'b11;
                end
                OP_J:     pc_src = PC_JUMP;
                OP_JAL: begin
                    ctrl.reg_write   = 1'b1;
                    ctrl.reg_dest    = 2'b10;
                    ctrl.data_to_reg = 2'b10;
                    pc_src           = PC_JUMP;
                end
                default: ctrl = '0;
            endcase
        end
    end

    ////////////////////////////////////////
    // Destination and source use

    always_comb begin
        hz.id_dest = DEST_NONE;
        hz.id_srcs = '{rs: id_insn.rs, rt: id_insn.rt,
                       uses_rs: 1'b0, uses_rt: 1'b0, is_branch: 1'b0};
        if (id_valid) begin
            case (id_insn.opcode)
                OP_R_TYPE: begin
                    if (r_known) begin
                        hz.id_dest         = '{addr: id_insn.rd, kind: RK_ALU};
                        hz.id_srcs.uses_rs = 1'b1;
                        hz.id_srcs.uses_rt = 1'b1;
                    end
                end
                OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_ADDIU, OP_SLTIU: begin
                    hz.id_dest         = '{addr: id_insn.rt, kind: RK_ALU};
                    hz.id_srcs.uses_rs = 1'b1;
                end
                OP_LW: begin
                    hz.id_dest         = '{addr: id_insn.rt, kind: RK_LOAD};
                    hz.id_srcs.uses_rs = 1'b1;
                end
                OP_SW:  hz.id_srcs.uses_rs = 1'b1;
                OP_LUI: hz.id_dest = '{addr: id_insn.rt, kind: RK_LUI};
                OP_BEQ, OP_BNE: begin
                    hz.id_srcs.uses_rs   = 1'b1;
                    hz.id_srcs.uses_rt   = 1'b1;
                    hz.id_srcs.is_branch = 1'b1;
                end
                default: hz.id_dest = DEST_NONE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/inflight_tracker.sv ====
// In-flight tracker, destination entries of the EX and MEM stage instructions
`timescale 1ns/1ns
`default_nettype none
`include "ctrl_macros.svh"

module inflight_tracker (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic [`PIPEREG_N-1:0] pipereg_we,
    input  wire logic [`PIPEREG_N-1:0] pipereg_zero,
    hazard_if.tracker                  hz
);
    import ctrl_pkg::*;

    // Follows the ID/EX register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hz.ex_dest <= DEST_NONE;
        end else if (pipereg_we[1]) begin
            hz.ex_dest <= pipereg_zero[1] ? DEST_NONE : hz.id_dest;
        end
    end

    // Follows the EX/MEM register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hz.mem_dest <= DEST_NONE;
        end else if (pipereg_we[2]) begin
            hz.mem_dest <= pipereg_zero[2] ? DEST_NONE : hz.ex_dest;
        end
    end

endmodule

`default_nettype wire

// ==== source/bypass_unit.sv ====
// Bypass unit, operand forwarding selects and load-use stall request
`timescale 1ns/1ns
`default_nettype none
`include "ctrl_macros.svh"

module bypass_unit (
    hazard_if.bypass              hz,
    output ctrl_pkg::bypass_sel_t alu_a_sel,
    output ctrl_pkg::bypass_sel_t alu_b_sel,
    output ctrl_pkg::bypass_sel_t branch_a_sel,
    output ctrl_pkg::bypass_sel_t branch_b_sel,
    output logic                  stall_req
);
    import ctrl_pkg::*;

    bypass_sel_t sel_a;
    bypass_sel_t sel_b;
    logic        load_ex;
    logic        load_mem;

    function automatic logic hits(dest_entry_t d, logic [`REG_ADDR_W-1:0] r);
        return (d.addr != '0) && (d.kind != RK_NONE) && (d.addr == r);
    endfunction

    // Youngest producer wins
    function automatic bypass_sel_t pick(logic used, logic [`REG_ADDR_W-1:0] r,
                                         dest_entry_t ex, dest_entry_t mem);
        bypass_sel_t sel;
        sel = BP_NONE;
        if (used && hits(ex, r)) begin
            case (ex.kind)
                RK_ALU:  sel = BP_EX_ALU;
                RK_LUI:  sel = BP_EX_LUI;
                default: sel = BP_NONE;
            endcase
        end else if (used && hits(mem, r)) begin
            case (mem.kind)
                RK_ALU:  sel = BP_MEM_ALU;
                RK_LUI:  sel = BP_MEM_LUI;
                RK_LOAD: sel = BP_MEM_LOAD;
                default: sel = BP_NONE;
            endcase
        end
        return sel;
    endfunction

    function automatic logic load_hit(logic used, logic [`REG_ADDR_W-1:0] r, dest_entry_t d);
        return used && hits(d, r) && (d.kind == RK_LOAD);
    endfunction

    assign sel_a = pick(hz.id_srcs.uses_rs, hz.id_srcs.rs, hz.ex_dest, hz.mem_dest);
    assign sel_b = pick(hz.id_srcs.uses_rt, hz.id_srcs.rt, hz.ex_dest, hz.mem_dest);

    assign load_ex  = load_hit(hz.id_srcs.uses_rs, hz.id_srcs.rs, hz.ex_dest)
                   || load_hit(hz.id_srcs.uses_rt, hz.id_srcs.rt, hz.ex_dest);
    assign load_mem = load_hit(hz.id_srcs.uses_rs, hz.id_srcs.rs, hz.mem_dest)
                   || load_hit(hz.id_srcs.uses_rt, hz.id_srcs.rt, hz.mem_dest);

    always_comb begin
        alu_a_sel    = BP_NONE;
        alu_b_sel    = BP_NONE;
        branch_a_sel = BP_NONE;
        branch_b_sel = BP_NONE;
        if (hz.id_srcs.is_branch) begin
            // Load data arrives too late for the compare in ID
            branch_a_sel = (sel_a == BP_MEM_LOAD) ? BP_NONE : sel_a;
            branch_b_sel = (sel_b == BP_MEM_LOAD) ? BP_NONE : sel_b;
            stall_req    = load_ex || load_mem;
        end else begin
            alu_a_sel = sel_a;
            alu_b_sel = sel_b;
            stall_req = load_ex;
        end
    end

endmodule

`default_nettype wire

// ==== source/stall_sequencer.sv ====
// Stall sequencer, debug single step, PC write and pipeline register enables
`timescale 1ns/1ns
`default_nettype none
`include "ctrl_macros.svh"

module stall_sequencer (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  debug_en,
    input  wire logic                  debug_step,
    input  wire logic                  stall_req,
    input  wire ctrl_pkg::pc_src_t     pc_src,
    output logic                       cpu_en,
    output logic                       pc_write,
    output logic [`PIPEREG_N-1:0]      pipereg_we,
    output logic [`PIPEREG_N-1:0]      pipereg_zero
);
    import ctrl_pkg::*;

    logic debug_step_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            debug_step_q <= 1'b0;
        end else begin
            debug_step_q <= debug_step;
        end
    end

    // Free running, or one cycle per rising step
    assign cpu_en = !debug_en || (debug_step && !debug_step_q);

    always_comb begin
        if (rst) begin
            pc_write     = 1'b0;
            pipereg_we   = 4'b0000;
            pipereg_zero = 4'b0000;
        end else if (!cpu_en) begin
            pc_write     = 1'b0;
            pipereg_we   = 4'b0000;
            pipereg_zero = 4'b1111;
        end else if (!stall_req) begin
            pc_write     = 1'b1;
            pipereg_we   = 4'b1111;
            // Squash the fetched slot on a redirect
            pipereg_zero = (pc_src != PC_SEQ) ? 4'b0001 : 4'b0000;
        end else begin
            // Hold IF and ID, bubble into EX
            pc_write     = 1'b0;
            pipereg_we   = 4'b1110;
            pipereg_zero = 4'b0010;
        end
    end

endmodule

`default_nettype wire

// ==== source/pipeline_controller.sv ====
// Pipeline controller, top level of decode, hazard tracking and stall control
`timescale 1ns/1ns
`default_nettype none
`include "ctrl_macros.svh"

module pipeline_controller (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  debug_en,
    input  wire logic                  debug_step,
    input  wire isa_pkg::insn_t        id_insn,
    input  wire logic                  id_valid,
    input  wire logic                  branch_equal,
    output logic                       cpu_en,
    output logic                       pc_write,
    output ctrl_pkg::pc_src_t          pc_src,
    output ctrl_pkg::ctrl_word_t       ctrl,
    output ctrl_pkg::bypass_sel_t      alu_a_sel,
    output ctrl_pkg::bypass_sel_t      alu_b_sel,
    output ctrl_pkg::bypass_sel_t      branch_a_sel,
    output ctrl_pkg::bypass_sel_t      branch_b_sel,
    output logic [`PIPEREG_N-1:0]      pipereg_we,
    output logic [`PIPEREG_N-1:0]      pipereg_zero
);
    logic stall_req;

    hazard_if i_hz ();

    instr_decoder i_decoder (
        .id_insn      (id_insn),
        .id_valid     (id_valid),
        .branch_equal (branch_equal),
        .ctrl         (ctrl),
        .pc_src       (pc_src),
        .hz           (i_hz.decoder)
    );

    inflight_tracker i_tracker (
        .clk          (clk),
        .rst          (rst),
        .pipereg_we   (pipereg_we),
        .pipereg_zero (pipereg_zero),
        .hz           (i_hz.tracker)
    );

    bypass_unit i_bypass (
        .hz           (i_hz.bypass),
        .alu_a_sel    (alu_a_sel),
        .alu_b_sel    (alu_b_sel),
        .branch_a_sel (branch_a_sel),
        .branch_b_sel (branch_b_sel),
        .stall_req    (stall_req)
    );

    stall_sequencer i_sequencer (
        .clk          (clk),
        .rst          (rst),
        .debug_en     (debug_en),
        .debug_step   (debug_step),
        .stall_req    (stall_req),
        .pc_src       (pc_src),
        .cpu_en       (cpu_en),
        .pc_write     (pc_write),
        .pipereg_we   (pipereg_we),
        .pipereg_zero (pipereg_zero)
    );

endmodule

`default_nettype wire

// ==== sim/pipeline_controller_properties.sv ====
// Enable rule properties of the pipeline controller, bound to its top level
`timescale 1ns/1ns
`default_nettype none
`include "ctrl_macros.svh"

module pipeline_controller_properties (
    input wire logic                  clk,
    input wire logic                  rst,
    input wire logic                  debug_en,
    input wire logic                  cpu_en,
    input wire logic                  stall_req,
    input wire logic                  pc_write,
    input wire ctrl_pkg::pc_src_t     pc_src,
    input wire logic [`PIPEREG_N-1:0] pipereg_we,
    input wire logic [`PIPEREG_N-1:0] pipereg_zero
);
    import ctrl_pkg::*;

    int unsigned fail_count = 0;

    ////////////////////////////////////////
    // Enable rules

    a_reset: assert property (@(posedge clk)
        rst |-> !pc_write && pipereg_we == 4'b0000 && pipereg_zero == 4'b0000)
    else begin
        fail_count++;
        $error("pipeline enables active during reset");
    end

    a_halt: assert property (@(posedge clk)
        !rst && !cpu_en |-> !pc_write && pipereg_we == 4'b0000 && pipereg_zero == 4'b1111)
    else begin
        fail_count++;
        $error("pipeline moved while the CPU was halted");
    end

    // Redirect squashes only the fetched slot
    a_run: assert property (@(posedge clk)
        !rst && cpu_en && !stall_req |-> pc_write && pipereg_we == 4'b1111
            && pipereg_zero == ((pc_src != PC_SEQ) ? 4'b0001 : 4'b0000))
    else begin
        fail_count++;
        $error("wrong enables in a cycle without stall");
    end

    a_stall: assert property (@(posedge clk)
        !rst && cpu_en && stall_req |-> !pc_write && pipereg_we == 4'b1110
            && pipereg_zero == 4'b0010)
    else begin
        fail_count++;
        $error("wrong enables in a stall cycle");
    end

    ////////////////////////////////////////
    // Debug step

    a_step: assert property (@(posedge clk)
        !rst && debug_en && cpu_en ##1 debug_en |-> !cpu_en)
    else begin
        fail_count++;
        $error("debug step lasted more than one cycle");
    end

endmodule

bind pipeline_controller pipeline_controller_properties i_props (
    .clk          (clk),
    .rst          (rst),
    .debug_en     (debug_en),
    .cpu_en       (cpu_en),
    .stall_req    (stall_req),
    .pc_write     (pc_write),
    .pc_src       (pc_src),
    .pipereg_we   (pipereg_we),
    .pipereg_zero (pipereg_zero)
);

`default_nettype wire

// ==== sim/tb_pipeline_controller.sv ====
// Testbench of the pipeline controller, decode, forwarding, load-use stalls and debug step
`timescale 1ns/1ns
`default_nettype none
`include "ctrl_macros.svh"

module tb_pipeline_controller;
    import isa_pkg::*;
    import ctrl_pkg::*;

    localparam int RESET_CYCLES   = 10;
    localparam int DEBUG_CYCLES   = 6;
    localparam int DECODE_CYCLES  = 33;
    localparam int FORWARD_CYCLES = 27;
    localparam int HAZARD_CYCLES  = 19;
    localparam int CYCLE_LIMIT    = RESET_CYCLES + DEBUG_CYCLES + DECODE_CYCLES
                                  + FORWARD_CYCLES + HAZARD_CYCLES + 50;

    // ALU operations that shift by shamt, SRA, SLL and SRL
    localparam logic [15:0] SHAMT_OPS = 16'b0000_0000_0011_1000;

    logic                  clk;
    logic                  rst;
    logic                  debug_en;
    logic                  debug_step;
    insn_t                 id_insn;
    logic                  id_valid;
    logic                  branch_equal;
    logic                  cpu_en;
    logic                  pc_write;
    pc_src_t               pc_src;
    ctrl_word_t            ctrl;
    bypass_sel_t           alu_a_sel;
    bypass_sel_t           alu_b_sel;
    bypass_sel_t           branch_a_sel;
    bypass_sel_t           branch_b_sel;
    logic [`PIPEREG_N-1:0] pipereg_we;
    logic [`PIPEREG_N-1:0] pipereg_zero;

    int         errors = 0;
    int         checks = 0;
    int         cycles = 0;
    integer     seed   = 32'h5d8cd649;
    logic [4:0] r;

    // Same order as the ALU operations
    funct_t fn_list [16] = '{FN_AND, FN_OR, FN_ADD, FN_SRA, FN_SLL, FN_SRL, FN_SUB, FN_SLT,
                             FN_ADDU, FN_SUBU, FN_SLTU, FN_XOR, FN_NOR, FN_SRAV, FN_SLLV,
                             FN_SRLV};

    pipeline_controller i_dut (
        .clk          (clk),
        .rst          (rst),
        .debug_en     (debug_en),
        .debug_step   (debug_step),
        .id_insn      (id_insn),
        .id_valid     (id_valid),
        .branch_equal (branch_equal),
        .cpu_en       (cpu_en),
        .pc_write     (pc_write),
        .pc_src       (pc_src),
        .ctrl         (ctrl),
        .alu_a_sel    (alu_a_sel),
        .alu_b_sel    (alu_b_sel),
        .branch_a_sel (branch_a_sel),
        .branch_b_sel (branch_b_sel),
        .pipereg_we   (pipereg_we),
        .pipereg_zero (pipereg_zero)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: no result after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [4:0] rand_reg();
        return 5'(($unsigned($random(seed)) % 31) + 1);
    endfunction

    function automatic insn_t make_insn(opcode_t op, logic [4:0] s, logic [4:0] t,
                                        logic [4:0] d, funct_t fn);
        return '{opcode: op, rs: s, rt: t, rd: d, shamt: '0, funct: fn};
    endfunction

    // fields: shamt, imm, zero ext, reg write, reg dest, data to reg, mem write, mem read
    function automatic ctrl_word_t ctrl_word(alu_op_t op, logic [9:0] fields);
        return ctrl_word_t'({op, fields});
    endfunction

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        assert (act === exp)
        else begin
            errors++;
            $display("error %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    task automatic advance_cycle();
        @(posedge clk);
        @(negedge clk);
    endtask

    // New instruction only once the IF/ID register accepts
    task automatic issue_insn(insn_t insn, logic valid, logic taken);
        while (pipereg_we[0] !== 1'b1) begin
            @(negedge clk);
        end
        @(posedge clk);
        id_insn      <= insn;
        id_valid     <= valid;
        branch_equal <= taken;
        @(negedge clk);
    endtask

    task automatic flush_pipe();
        repeat (2) begin
            issue_insn('0, 1'b0, 1'b0);
        end
    endtask

    task automatic decode_case(opcode_t op, funct_t fn, logic taken, ctrl_word_t exp,
                               pc_src_t exp_pc);
        issue_insn(make_insn(op, '0, '0, rand_reg(), fn), 1'b1, taken);
        check_value("ctrl", 32'(exp), 32'(ctrl));
        check_value("pc_src", 32'(exp_pc), 32'(pc_src));
    endtask

    task automatic forward_case(insn_t producer, logic [4:0] reg_n, int gap, bypass_sel_t exp);
        flush_pipe();
        issue_insn(producer, 1'b1, 1'b0);
        repeat (gap) begin
            issue_insn('0, 1'b0, 1'b0);
        end
        issue_insn(make_insn(OP_R_TYPE, reg_n, reg_n, '0, FN_ADD), 1'b1, 1'b0);
        check_value("alu_a_sel", 32'(exp), 32'(alu_a_sel));
        check_value("alu_b_sel", 32'(exp), 32'(alu_b_sel));
        check_value("pc_write", 32'h1, 32'(pc_write));
    endtask

    initial begin
        rst          = 1'b1;
        debug_en     = 1'b0;
        debug_step   = 1'b0;
        id_insn      = '0;
        id_valid     = 1'b0;
        branch_equal = 1'b0;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_value("pc_write", 32'h0, 32'(pc_write));
            check_value("pipereg_we", 32'h0, 32'(pipereg_we));
        end

        ////////////////////////////////////////
        // Debug single step
        @(posedge clk);
        rst      <= 1'b0;
        debug_en <= 1'b1;
        @(negedge clk);
        check_value("cpu_en", 32'h0, 32'(cpu_en));
        advance_cycle();
        check_value("cpu_en", 32'h0, 32'(cpu_en));
        @(posedge clk);
        debug_step <= 1'b1;
        @(negedge clk);
        check_value("cpu_en", 32'h1, 32'(cpu_en));
        advance_cycle();
        check_value("cpu_en", 32'h0, 32'(cpu_en));
        @(posedge clk);
        debug_step <= 1'b0;
        debug_en   <= 1'b0;
        @(negedge clk);
        check_value("cpu_en", 32'h1, 32'(cpu_en));

        ////////////////////////////////////////
        // Decode table
        for (int i = 0; i < 16; i++) begin
            decode_case(OP_R_TYPE, fn_list[i], 1'b0,
                        ctrl_word(alu_op_t'(4'(i)), {SHAMT_OPS[i], 9'b001_01_00_00}),
                        PC_SEQ);
        end
        decode_case(OP_ADDI,  FN_SLL, 1'b0, ctrl_word(ALU_ADD,  10'b0101_00_00_00), PC_SEQ);
        decode_case(OP_ANDI,  FN_SLL, 1'b0, ctrl_word(ALU_AND,  10'b0111_00_00_00), PC_SEQ);
        decode_case(OP_ORI,   FN_SLL, 1'b0, ctrl_word(ALU_OR,   10'b0111_00_00_00), PC_SEQ);
        decode_case(OP_XORI,  FN_SLL, 1'b0, ctrl_word(ALU_XOR,  10'b0111_00_00_00), PC_SEQ);
        decode_case(OP_SLTI,  FN_SLL, 1'b0, ctrl_word(ALU_SLT,  10'b0101_00_00_00), PC_SEQ);
        decode_case(OP_ADDIU, FN_SLL, 1'b0, ctrl_word(ALU_ADDU, 10'b0111_00_00_00), PC_SEQ);
        decode_case(OP_SLTIU, FN_SLL, 1'b0, ctrl_word(ALU_SLTU, 10'b0111_00_00_00), PC_SEQ);
        decode_case(OP_LW,    FN_SLL, 1'b0, ctrl_word(ALU_ADD,  10'b0101_00_01_01), PC_SEQ);
        decode_case(OP_SW,    FN_SLL, 1'b0, ctrl_word(ALU_ADD,  10'b0100_00_00_10), PC_SEQ);
        decode_case(OP_LUI,   FN_SLL, 1'b0, ctrl_word(ALU_AND,  10'b0001_00_11_00), PC_SEQ);
        decode_case(OP_J,     FN_SLL, 1'b0, ctrl_word(ALU_AND,  10'b0000_00_00_00), PC_JUMP);
        decode_case(OP_JAL,   FN_SLL, 1'b0, ctrl_word(ALU_AND,  10'b0001_10_10_00), PC_JUMP);
        decode_case(OP_BEQ,   FN_SLL, 1'b1, ctrl_word(ALU_SUB,  10'b0000_00_00_00), PC_BRANCH);
        decode_case(OP_BEQ,   FN_SLL, 1'b0, ctrl_word(ALU_SUB,  10'b0000_00_00_00), PC_SEQ);
        decode_case(OP_BNE,   FN_SLL, 1'b1, ctrl_word(ALU_SUB,  10'b0000_00_00_00), PC_SEQ);
        decode_case(OP_BNE,   FN_SLL, 1'b0, ctrl_word(ALU_SUB,  10'b0000_00_00_00), PC_BRANCH);
        // A bubble decodes to nothing
        issue_insn(make_insn(OP_ADDI, '0, '0, '0, FN_SLL), 1'b0, 1'b0);
        check_value("ctrl", 32'h0, 32'(ctrl));
        check_value("pc_src", 32'(PC_SEQ), 32'(pc_src));

        ////////////////////////////////////////
        // Forwarding
        r = rand_reg();
        forward_case(make_insn(OP_R_TYPE, '0, '0, r, FN_ADD), r, 0, BP_EX_ALU);
        forward_case(make_insn(OP_R_TYPE, '0, '0, r, FN_ADD), r, 1, BP_MEM_ALU);
        forward_case(make_insn(OP_LUI, '0, r, '0, FN_SLL), r, 0, BP_EX_LUI);
        forward_case(make_insn(OP_LUI, '0, r, '0, FN_SLL), r, 1, BP_MEM_LUI);
        forward_case(make_insn(OP_LW, '0, r, '0, FN_SLL), r, 1, BP_MEM_LOAD);
        forward_case(make_insn(OP_R_TYPE, '0, '0, '0, FN_ADD), '0, 0, BP_NONE);

        ////////////////////////////////////////
        // Load-use and branch hazards
        r = rand_reg();
        flush_pipe();
        issue_insn(make_insn(OP_LW, '0, r, '0, FN_SLL), 1'b1, 1'b0);
        issue_insn(make_insn(OP_ADDI, r, '0, '0, FN_SLL), 1'b1, 1'b0);
        check_value("pc_write", 32'h0, 32'(pc_write));
        check_value("pipereg_we", 32'he, 32'(pipereg_we));
        check_value("pipereg_zero", 32'h2, 32'(pipereg_zero));
        advance_cycle();
        check_value("alu_a_sel", 32'(BP_MEM_LOAD), 32'(alu_a_sel));
        check_value("pipereg_we", 32'hf, 32'(pipereg_we));

        // Branch waits for the load through EX and MEM
        flush_pipe();
        issue_insn(make_insn(OP_LW, '0, r, '0, FN_SLL), 1'b1, 1'b0);
        issue_insn(make_insn(OP_BEQ, r, '0, '0, FN_SLL), 1'b1, 1'b0);
        check_value("pc_write", 32'h0, 32'(pc_write));
        advance_cycle();
        check_value("pc_write", 32'h0, 32'(pc_write));
        check_value("branch_a_sel", 32'(BP_NONE), 32'(branch_a_sel));
        advance_cycle();
        check_value("pc_write", 32'h1, 32'(pc_write));
        check_value("branch_a_sel", 32'(BP_NONE), 32'(branch_a_sel));

        flush_pipe();
        issue_insn(make_insn(OP_R_TYPE, '0, '0, r, FN_ADD), 1'b1, 1'b0);
        issue_insn(make_insn(OP_BEQ, r, r, '0, FN_SLL), 1'b1, 1'b0);
        check_value("branch_a_sel", 32'(BP_EX_ALU), 32'(branch_a_sel));
        check_value("branch_b_sel", 32'(BP_EX_ALU), 32'(branch_b_sel));
        check_value("alu_a_sel", 32'(BP_NONE), 32'(alu_a_sel));
        check_value("pc_write", 32'h1, 32'(pc_write));

        // Taken branch, then jump
        flush_pipe();
        issue_insn(make_insn(OP_BEQ, '0, '0, '0, FN_SLL), 1'b1, 1'b1);
        check_value("pipereg_zero", 32'h1, 32'(pipereg_zero));
        check_value("pc_write", 32'h1, 32'(pc_write));
        issue_insn(make_insn(OP_J, '0, '0, '0, FN_SLL), 1'b1, 1'b0);
        check_value("pipereg_zero", 32'h1, 32'(pipereg_zero));
        check_value("pc_write", 32'h1, 32'(pc_write));

        $display("errors: %0d of %0d checks, assertion failures: %0d",
                 errors, checks, i_dut.i_props.fail_count);
        if (errors == 0 && i_dut.i_props.fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+include
source/isa_pkg.sv
source/ctrl_pkg.sv
source/hazard_if.sv
source/instr_decoder.sv
source/inflight_tracker.sv
source/bypass_unit.sv
source/stall_sequencer.sv
source/pipeline_controller.sv
sim/pipeline_controller_properties.sv
sim/tb_pipeline_controller.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --assert --timing --timescale 1ns/1ns -j 0 -f all.f \
		--top-module tb_pipeline_controller -o tb_sim
	./obj_dir/tb_sim +verilator+error+limit+1000 | \
		awk '{ print } /^Simulation passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
